// File: Bender.yml
package:
  name: axi_sram

sources:
  # Package
  - src/axi_sram_pkg.sv
  # RTL
  - src/axi_burst_decode.sv
  - src/sram_exec.sv
  - src/axi_resp_slot.sv
  - src/axi_sram_top.sv
  # Testbench
  - target: test
    files:
      - tb/axi_sram_sva.sv
      - tb/axi_sram_tb.sv

// File: build.f
src/axi_sram_pkg.sv
src/axi_burst_decode.sv
src/sram_exec.sv
src/axi_resp_slot.sv
src/axi_sram_top.sv
tb/axi_sram_sva.sv
tb/axi_sram_tb.sv

// File: src/axi_burst_decode.sv
// AXI burst address decoder
module axi_burst_decode
  import axi_sram_pkg::*;
(
  input  logic              i_aclk,
  input  logic              i_arst_n,
  input  logic [ID_W-1:0]   i_id,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [LEN_W-1:0]  i_len,
  input  logic [2:0]        i_size,
  input  logic [1:0]        i_burst,
  input  logic              i_valid,
  input  logic              i_step,
  output logic              o_ready,
  output logic              o_active,
  output logic [ADDR_W-1:0] o_beat_addr,
  output logic              o_beat_err,
  output logic              o_last,
  output logic [ID_W-1:0]   o_id
);

  logic              active_q;
  logic [LEN_W-1:0]  beat_cnt_q;
  logic [ID_W-1:0]   id_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  len_q;
  logic [2:0]        size_q;
  logic [1:0]        burst_q;
  logic              accept;
  logic              advance;
  logic [ADDR_W-1:0] step_bytes;
  logic [ADDR_W-1:0] wrap_mask;
  logic [ADDR_W-1:0] incr_addr;
  logic [ADDR_W-1:0] next_addr;

  assign accept  = i_valid && !active_q;
  assign advance = i_step && active_q;

  // --------------------------------------------------------------------------
  // Next beat address
  // --------------------------------------------------------------------------
  assign step_bytes = ADDR_W'(1) << size_q;
  assign incr_addr  = addr_q + step_bytes;
  // Wrap window is (len+1) beats of 2^size bytes
  assign wrap_mask  = ((ADDR_W'(len_q) + ADDR_W'(1)) << size_q) - ADDR_W'(1);

  always_comb begin
    case (burst_q)
      BURST_FIXED: next_addr = addr_q;
      BURST_WRAP:  next_addr = (addr_q & ~wrap_mask) | (incr_addr & wrap_mask);
      default:     next_addr = incr_addr;
    endcase
  end

  // --------------------------------------------------------------------------
  // Burst state
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      active_q   <= 1'b0;
      beat_cnt_q <= '0;
    end else if (accept) begin
      active_q   <= 1'b1;
      beat_cnt_q <= '0;
    end else if (advance) begin
      if (o_last) begin
        active_q <= 1'b0;
      end
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (accept) begin
      id_q    <= i_id;
      addr_q  <= i_addr;
      len_q   <= i_len;
      size_q  <= i_size;
      burst_q <= i_burst;
    end else if (advance) begin
      addr_q <= next_addr;
    end
  end

  assign o_ready     = !active_q;
  assign o_active    = active_q;
  assign o_beat_addr = addr_q;
  assign o_beat_err  = addr_q >= ADDR_W'(MEM_BYTES);
  assign o_last      = active_q && (beat_cnt_q == len_q);
  assign o_id        = id_q;

endmodule

// File: src/axi_resp_slot.sv
// Result slot FIFO
module axi_resp_slot
  import axi_sram_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic                  i_aclk,
  input  logic                  i_arst_n,
  input  logic                  i_push,
  input  payload_t              i_payload,
  input  logic                  i_ready,
  output logic [SLOT_CNT_W-1:0] o_free,
  output logic                  o_valid,
  output payload_t              o_payload
);

  payload_t              entries [SLOT_DEPTH];
  logic [SLOT_CNT_W-1:0] wr_ptr_q;
  logic [SLOT_CNT_W-1:0] rd_ptr_q;
  logic [SLOT_CNT_W-1:0] count_q;
  logic [SLOT_CNT_W-1:0] count_next;
  logic                  valid_q;
  logic                  pop;

  function automatic logic [SLOT_CNT_W-1:0] ptr_inc(input logic [SLOT_CNT_W-1:0] p);
    return (p == SLOT_CNT_W'(SLOT_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop = valid_q && i_ready;

  always_comb begin
    count_next = count_q;
    case ({i_push, pop})
      2'b10:   count_next = count_q + 1'b1;
      2'b01:   count_next = count_q - 1'b1;
      default: count_next = count_q;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      valid_q  <= 1'b0;
    end else begin
      if (i_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_next;
      valid_q <= count_next != '0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_push) begin
      entries[wr_ptr_q] <= i_payload;
    end
  end

  assign o_free    = SLOT_CNT_W'(SLOT_DEPTH) - count_q;
  assign o_valid   = valid_q;
  assign o_payload = entries[rd_ptr_q];

endmodule

// File: src/axi_sram_pkg.sv
// AXI SRAM shared definitions
package axi_sram_pkg;

  // --------------------------------------------------------------------------
  // Bus and memory geometry
  // --------------------------------------------------------------------------
  localparam int DATA_W     = 64;
  localparam int STRB_W     = DATA_W / 8;
  localparam int ADDR_W     = 32;
  localparam int ID_W       = 4;
  localparam int LEN_W      = 8;
  localparam int MEM_WORDS  = 256;
  localparam int MEM_BYTES  = MEM_WORDS * STRB_W;
  localparam int WORD_IDX_W = $clog2(MEM_WORDS);
  localparam int BYTE_OFF_W = $clog2(STRB_W);

  // Result slot sizing, counters must hold 0..SLOT_DEPTH
  localparam int SLOT_DEPTH = 3;
  localparam int SLOT_CNT_W = 2;

  // --------------------------------------------------------------------------
  // AXI encodings
  // --------------------------------------------------------------------------
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Result payloads
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_beat_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_resp_t;

endpackage

// File: src/axi_sram_top.sv
// AXI4 SRAM slave
module axi_sram_top
  import axi_sram_pkg::*;
(
  input  logic              i_aclk,
  input  logic              i_arst_n,

  // Write address channel
  input  logic [ID_W-1:0]   i_awid,
  input  logic [ADDR_W-1:0] i_awaddr,
  input  logic [LEN_W-1:0]  i_awlen,
  input  logic [2:0]        i_awsize,
  input  logic [1:0]        i_awburst,
  input  logic [1:0]        i_awlock,
  input  logic [3:0]        i_awcache,
  input  logic [2:0]        i_awprot,
  input  logic              i_awvalid,
  output logic              o_awready,

  // Write data channel
  input  logic [ID_W-1:0]   i_wid,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic [STRB_W-1:0] i_wstrb,
  input  logic              i_wlast,
  input  logic              i_wvalid,
  output logic              o_wready,

  // Write response channel
  output logic [ID_W-1:0]   o_bid,
  output logic [1:0]        o_bresp,
  output logic              o_bvalid,
  input  logic              i_bready,

  // Read address channel
  input  logic [ID_W-1:0]   i_arid,
  input  logic [ADDR_W-1:0] i_araddr,
  input  logic [LEN_W-1:0]  i_arlen,
  input  logic [2:0]        i_arsize,
  input  logic [1:0]        i_arburst,
  input  logic [1:0]        i_arlock,
  input  logic [3:0]        i_arcache,
  input  logic [2:0]        i_arprot,
  input  logic              i_arvalid,
  output logic              o_arready,

  // Read data channel
  output logic [ID_W-1:0]   o_rid,
  output logic [DATA_W-1:0] o_rdata,
  output logic [1:0]        o_rresp,
  output logic              o_rlast,
  output logic              o_rvalid,
  input  logic              i_rready
);

  logic                  wr_active;
  logic [ADDR_W-1:0]     wr_addr;
  logic                  wr_err;
  logic                  wr_last;
  logic [ID_W-1:0]       wr_id;
  logic                  wr_step;
  logic                  rd_active;
  logic [ADDR_W-1:0]     rd_addr;
  logic                  rd_err;
  logic                  rd_last;
  logic [ID_W-1:0]       rd_id;
  logic                  rd_step;
  logic                  b_push;
  b_resp_t               b_payload;
  b_resp_t               b_out;
  logic [SLOT_CNT_W-1:0] b_free;
  logic                  r_push;
  r_beat_t               r_payload;
  r_beat_t               r_out;
  logic [SLOT_CNT_W-1:0] r_free;

  // --------------------------------------------------------------------------
  // Address decoders
  // --------------------------------------------------------------------------
  axi_burst_decode u_wr_dec (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_id        (i_awid),
    .i_addr      (i_awaddr),
    .i_len       (i_awlen),
    .i_size      (i_awsize),
    .i_burst     (i_awburst),
    .i_valid     (i_awvalid),
    .i_step      (wr_step),
    .o_ready     (o_awready),
    .o_active    (wr_active),
    .o_beat_addr (wr_addr),
    .o_beat_err  (wr_err),
    .o_last      (wr_last),
    .o_id        (wr_id)
  );

  axi_burst_decode u_rd_dec (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_id        (i_arid),
    .i_addr      (i_araddr),
    .i_len       (i_arlen),
    .i_size      (i_arsize),
    .i_burst     (i_arburst),
    .i_valid     (i_arvalid),
    .i_step      (rd_step),
    .o_ready     (o_arready),
    .o_active    (rd_active),
    .o_beat_addr (rd_addr),
    .o_beat_err  (rd_err),
    .o_last      (rd_last),
    .o_id        (rd_id)
  );

  // --------------------------------------------------------------------------
  // Execute stage
  // --------------------------------------------------------------------------
  sram_exec u_exec (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_wr_active (wr_active),
    .i_wr_addr   (wr_addr),
    .i_wr_err    (wr_err),
    .i_wr_last   (wr_last),
    .i_wr_id     (wr_id),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wvalid    (i_wvalid),
    .i_b_free    (b_free),
    .o_wready    (o_wready),
    .o_wr_step   (wr_step),
    .o_b_push    (b_push),
    .o_b_payload (b_payload),
    .i_rd_active (rd_active),
    .i_rd_addr   (rd_addr),
    .i_rd_err    (rd_err),
    .i_rd_last   (rd_last),
    .i_rd_id     (rd_id),
    .i_r_free    (r_free),
    .o_rd_step   (rd_step),
    .o_r_push    (r_push),
    .o_r_payload (r_payload)
  );

  // --------------------------------------------------------------------------
  // Output slots
  // --------------------------------------------------------------------------
  axi_resp_slot #(
    .payload_t (b_resp_t)
  ) u_b_slot (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_push    (b_push),
    .i_payload (b_payload),
    .i_ready   (i_bready),
    .o_free    (b_free),
    .o_valid   (o_bvalid),
    .o_payload (b_out)
  );

  axi_resp_slot #(
    .payload_t (r_beat_t)
  ) u_r_slot (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_push    (r_push),
    .i_payload (r_payload),
    .i_ready   (i_rready),
    .o_free    (r_free),
    .o_valid   (o_rvalid),
    .o_payload (r_out)
  );

  assign o_bid   = b_out.id;
  assign o_bresp = b_out.resp;
  assign o_rid   = r_out.id;
  assign o_rdata = r_out.data;
  assign o_rresp = r_out.resp;
  assign o_rlast = r_out.last;

endmodule

// File: src/sram_exec.sv
// SRAM array and beat engines
module sram_exec
  import axi_sram_pkg::*;
(
  input  logic                  i_aclk,
  input  logic                  i_arst_n,
  // Write side
  input  logic                  i_wr_active,
  input  logic [ADDR_W-1:0]     i_wr_addr,
  input  logic                  i_wr_err,
  input  logic                  i_wr_last,
  input  logic [ID_W-1:0]       i_wr_id,
  input  logic [DATA_W-1:0]     i_wdata,
  input  logic [STRB_W-1:0]     i_wstrb,
  input  logic                  i_wvalid,
  input  logic [SLOT_CNT_W-1:0] i_b_free,
  output logic                  o_wready,
  output logic                  o_wr_step,
  output logic                  o_b_push,
  output b_resp_t               o_b_payload,
  // Read side
  input  logic                  i_rd_active,
  input  logic [ADDR_W-1:0]     i_rd_addr,
  input  logic                  i_rd_err,
  input  logic                  i_rd_last,
  input  logic [ID_W-1:0]       i_rd_id,
  input  logic [SLOT_CNT_W-1:0] i_r_free,
  output logic                  o_rd_step,
  output logic                  o_r_push,
  output r_beat_t               o_r_payload
);

  logic [DATA_W-1:0]     mem [MEM_WORDS];
  logic [WORD_IDX_W-1:0] wr_idx;
  logic [WORD_IDX_W-1:0] rd_idx;
  logic                  w_fire;
  logic                  wr_err_q;
  logic                  rd_issue;
  logic                  rd_inflight_q;
  logic [DATA_W-1:0]     rd_data_q;
  logic [ID_W-1:0]       rd_id_q;
  logic                  rd_err_q;
  logic                  rd_last_q;

  assign wr_idx = i_wr_addr[BYTE_OFF_W +: WORD_IDX_W];
  assign rd_idx = i_rd_addr[BYTE_OFF_W +: WORD_IDX_W];

  // --------------------------------------------------------------------------
  // Write engine
  // --------------------------------------------------------------------------
  assign o_wready  = i_wr_active && (i_b_free != '0);
  assign w_fire    = i_wvalid && o_wready;
  assign o_wr_step = w_fire;
  assign o_b_push  = w_fire && i_wr_last;

  always_ff @(posedge i_aclk) begin
    if (w_fire && !i_wr_err) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // Sticky error over the burst, cleared by the last beat
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_err_q <= 1'b0;
    end else if (w_fire) begin
      wr_err_q <= i_wr_last ? 1'b0 : (wr_err_q || i_wr_err);
    end
  end

  always_comb begin
    o_b_payload.id   = i_wr_id;
    o_b_payload.resp = (wr_err_q || i_wr_err) ? RESP_SLVERR : RESP_OKAY;
  end

  // --------------------------------------------------------------------------
  // Read engine
  // --------------------------------------------------------------------------
  // Issue only while the slot keeps room for the beat already in flight
  assign rd_issue  = i_rd_active && (i_r_free > SLOT_CNT_W'(rd_inflight_q));
  assign o_rd_step = rd_issue;
  assign o_r_push  = rd_inflight_q;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_inflight_q <= 1'b0;
    end else begin
      rd_inflight_q <= rd_issue;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (rd_issue) begin
      rd_data_q <= mem[rd_idx];
      rd_id_q   <= i_rd_id;
      rd_err_q  <= i_rd_err;
      rd_last_q <= i_rd_last;
    end
  end

  always_comb begin
    o_r_payload.id   = rd_id_q;
    o_r_payload.data = rd_err_q ? '0 : rd_data_q;
    o_r_payload.resp = rd_err_q ? RESP_SLVERR : RESP_OKAY;
    o_r_payload.last = rd_last_q;
  end

endmodule

// File: tb/axi_sram_sva.sv
// AXI SRAM protocol assertions
module axi_sram_sva
  import axi_sram_pkg::*;
(
  input logic              i_aclk,
  input logic              i_arst_n,
  input logic              i_awvalid,
  input logic              o_awready,
  input logic              i_arvalid,
  input logic              o_arready,
  input logic [LEN_W-1:0]  i_arlen,
  input logic              i_wvalid,
  input logic              o_wready,
  input logic              i_wlast,
  input logic              i_wr_last,
  input logic              o_rvalid,
  input logic              i_rready,
  input logic [ID_W-1:0]   o_rid,
  input logic [DATA_W-1:0] o_rdata,
  input logic [1:0]        o_rresp,
  input logic              o_rlast,
  input logic              o_bvalid,
  input logic              i_bready,
  input logic [ID_W-1:0]   o_bid,
  input logic [1:0]        o_bresp
);

  logic [15:0] rd_pending_q;
  logic        wr_open_q;

  // Read beats accepted on AR but not yet delivered
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_pending_q <= '0;
    end else begin
      rd_pending_q <= rd_pending_q + ((i_arvalid && o_arready) ? (16'(i_arlen) + 16'd1) : 16'd0)
                      - ((o_rvalid && i_rready) ? 16'd1 : 16'd0);
    end
  end

  // Write burst open from AW acceptance to the WLAST beat
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_open_q <= 1'b0;
    end else if (i_awvalid && o_awready) begin
      wr_open_q <= 1'b1;
    end else if (i_wvalid && o_wready && i_wlast) begin
      wr_open_q <= 1'b0;
    end
  end

  r_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable({o_rid, o_rdata, o_rresp, o_rlast}))
    else $error("R payload changed before ready");

  b_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable({o_bid, o_bresp}))
    else $error("B payload changed before ready");

  wlast_match: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_wvalid && o_wready |-> i_wlast == i_wr_last)
    else $error("WLAST disagrees with the burst length");

  wready_idle: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_wready |-> wr_open_q)
    else $error("WREADY high with no write burst active");

  r_after_ar: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_rvalid |-> rd_pending_q != '0)
    else $error("R beat without an accepted AR");

endmodule

bind axi_sram_top axi_sram_sva u_sva (
  .i_aclk    (i_aclk),
  .i_arst_n  (i_arst_n),
  .i_awvalid (i_awvalid),
  .o_awready (o_awready),
  .i_arvalid (i_arvalid),
  .o_arready (o_arready),
  .i_arlen   (i_arlen),
  .i_wvalid  (i_wvalid),
  .o_wready  (o_wready),
  .i_wlast   (i_wlast),
  .i_wr_last (wr_last),
  .o_rvalid  (o_rvalid),
  .i_rready  (i_rready),
  .o_rid     (o_rid),
  .o_rdata   (o_rdata),
  .o_rresp   (o_rresp),
  .o_rlast   (o_rlast),
  .o_bvalid  (o_bvalid),
  .i_bready  (i_bready),
  .o_bid     (o_bid),
  .o_bresp   (o_bresp)
);

// File: tb/axi_sram_tb.sv
// AXI SRAM slave testbench
module axi_sram_tb
  import axi_sram_pkg::*;
;

  // Fill, directed, random, wrap, fixed, back-pressure, range and alias beats
  localparam int PLANNED_BEATS = 256 + 2 + 384 + 56 + 8 + 192 + 56 + 40 + 16;
  localparam int CYCLE_LIMIT   = PLANNED_BEATS * 8 + 2000;
  localparam logic [15:0] SEED = 16'd12387;

  logic i_aclk, i_arst_n;
  logic [ID_W-1:0] i_awid, i_arid, i_wid;
  logic [ADDR_W-1:0] i_awaddr, i_araddr;
  logic [LEN_W-1:0] i_awlen, i_arlen;
  logic [2:0] i_awsize, i_arsize, i_awprot, i_arprot;
  logic [1:0] i_awburst, i_arburst, i_awlock, i_arlock;
  logic [3:0] i_awcache, i_arcache;
  logic i_awvalid, i_arvalid, i_wvalid, i_wlast, i_bready, i_rready;
  logic [DATA_W-1:0] i_wdata;
  logic [STRB_W-1:0] i_wstrb;
  logic o_awready, o_arready, o_wready, o_bvalid, o_rvalid, o_rlast;
  logic [ID_W-1:0] o_bid, o_rid;
  logic [1:0] o_bresp, o_rresp;
  logic [DATA_W-1:0] o_rdata;

  logic [7:0] shadow [MEM_BYTES];
  r_beat_t r_exp [$];
  b_resp_t b_exp [$];
  r_beat_t want_r;
  b_resp_t want_b;
  logic [15:0] data_lfsr = SEED;
  logic [15:0] ready_lfsr = SEED;
  logic bp_on = 1'b0;
  int r_errs = 0;
  int b_errs = 0;
  int other_errs = 0;
  int cycles = 0;

  axi_sram_top i_dut (.*);

  initial begin
    i_aclk = 1'b0;
    forever #2 i_aclk = ~i_aclk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[62:0], data_lfsr[0]};
    end
  endtask

  // Address of beat idx per the AXI burst rules
  function automatic logic [ADDR_W-1:0] beat_addr(input logic [ADDR_W-1:0] a, input int len,
                                                   input int size, input logic [1:0] burst,
                                                   input int idx);
    int unsigned step;
    int unsigned total;
    logic [ADDR_W-1:0] base;
    step  = 1 << size;
    total = (len + 1) * step;
    base  = a - (a % total);
    if (burst == BURST_FIXED) return a;
    if (burst == BURST_WRAP) return base + ((a - base + idx * step) % total);
    return a + idx * step;
  endfunction

  function automatic r_beat_t ref_beat(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] a,
                                       input int len, input int size, input logic [1:0] burst,
                                       input int idx);
    r_beat_t r;
    logic [ADDR_W-1:0] ba;
    ba = beat_addr(a, len, size, burst, idx);
    r.id   = id;
    r.last = (idx == len);
    r.data = '0;
    r.resp = RESP_SLVERR;
    if (ba < MEM_BYTES) begin
      r.resp = RESP_OKAY;
      for (int b = 0; b < STRB_W; b++) r.data[8*b +: 8] = shadow[{ba[31:3], 3'b000} + b];
    end
    return r;
  endfunction

  task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] a,
                             input int len, input int size, input logic [1:0] burst,
                             input bit full_strb);
    b_resp_t eb;
    logic [63:0] d;
    logic [63:0] s;
    logic [ADDR_W-1:0] ba;
    eb.id   = id;
    eb.resp = RESP_OKAY;
    for (int i = 0; i <= len; i++)
      if (beat_addr(a, len, size, burst, i) >= MEM_BYTES) eb.resp = RESP_SLVERR;
    b_exp.push_back(eb);
    @(negedge i_aclk);
    i_awid    = id;
    i_awaddr  = a;
    i_awlen   = len;
    i_awsize  = size;
    i_awburst = burst;
    i_awvalid = 1'b1;
    do @(posedge i_aclk); while (!o_awready);
    for (int i = 0; i <= len; i++) begin
      take_bits(64, d);
      take_bits(8, s);
      if (full_strb) s = 64'hFF;
      @(negedge i_aclk);
      i_awvalid = 1'b0;
      i_wdata   = d;
      i_wstrb   = s[7:0];
      i_wlast   = (i == len);
      i_wvalid  = 1'b1;
      do @(posedge i_aclk); while (!o_wready);
      ba = beat_addr(a, len, size, burst, i);
      if (ba < MEM_BYTES)
        for (int b = 0; b < STRB_W; b++)
          if (s[b]) shadow[{ba[31:3], 3'b000} + b] = d[8*b +: 8];
    end
    @(negedge i_aclk);
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
    while (b_exp.size() != 0) @(posedge i_aclk);
  endtask

  task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] a,
                            input int len, input int size, input logic [1:0] burst);
    for (int i = 0; i <= len; i++) r_exp.push_back(ref_beat(id, a, len, size, burst, i));
    @(negedge i_aclk);
    i_arid    = id;
    i_araddr  = a;
    i_arlen   = len;
    i_arsize  = size;
    i_arburst = burst;
    i_arvalid = 1'b1;
    do @(posedge i_aclk); while (!o_arready);
    @(negedge i_aclk);
    i_arvalid = 1'b0;
    while (r_exp.size() != 0) @(posedge i_aclk);
  endtask

  task automatic write_read(input logic [ADDR_W-1:0] a, input int len, input int size,
                            input logic [1:0] burst);
    logic [63:0] ids;
    take_bits(8, ids);
    write_burst(ids[3:0], a, len, size, burst, 1'b0);
    read_burst(ids[7:4], a, len, size, burst);
  endtask

  task automatic random_incr();
    logic [63:0] v;
    take_bits(14, v);
    write_read((v[7:0] % 240) * 8, v[11:8], 2 + v[12], BURST_INCR);
  endtask

  // Start one beat past the middle of an aligned window
  task automatic wrap_set();
    logic [63:0] v;
    int n;
    for (int k = 2; k <= 4; k++) begin
      n = 1 << k;
      take_bits(4, v);
      write_read((v[3:0] % (256 / n)) * n * 8 + (n / 2 + 1) * 8, n - 1, 3, BURST_WRAP);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Ready patterns and response compare
  // ---------------------------------------------------------------------------
  always @(negedge i_aclk) begin
    if (bp_on) begin
      ready_lfsr = lfsr_next(ready_lfsr);
      i_rready   = ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
      i_bready   = ready_lfsr[0];
    end else begin
      i_rready = 1'b1;
      i_bready = 1'b1;
    end
  end

  always @(posedge i_aclk) begin
    if (i_arst_n && o_rvalid && i_rready) begin
      assert (r_exp.size() != 0) else begin
        other_errs++;
        $display("An R beat arrived while no read was pending, time %0t", $time);
      end
      if (r_exp.size() != 0) begin
        want_r = r_exp.pop_front();
        assert ({o_rid, o_rdata, o_rresp, o_rlast} === want_r) else begin
          r_errs++;
          $display("** Error at %0t: R got id %h data %h resp %h last %b, expected %h %h %h %b",
                   $time, o_rid, o_rdata, o_rresp, o_rlast,
                   want_r.id, want_r.data, want_r.resp, want_r.last);
        end
      end
    end
    if (i_arst_n && o_bvalid && i_bready) begin
      assert (b_exp.size() != 0) else begin
        other_errs++;
        $display("A B response arrived while no write was pending, time %0t", $time);
      end
      if (b_exp.size() != 0) begin
        want_b = b_exp.pop_front();
        assert ({o_bid, o_bresp} === want_b) else begin
          b_errs++;
          $display("** Error at %0t: B got id %h resp %h, expected %h %h",
                   $time, o_bid, o_bresp, want_b.id, want_b.resp);
        end
      end
    end
  end

  always @(posedge i_aclk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    i_arst_n  = 1'b0;
    i_awid    = '0;
    i_awaddr  = '0;
    i_awlen   = '0;
    i_awsize  = '0;
    i_awburst = '0;
    i_awlock  = '0;
    i_awcache = '0;
    i_awprot  = '0;
    i_awvalid = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_arlen   = '0;
    i_arsize  = '0;
    i_arburst = '0;
    i_arlock  = '0;
    i_arcache = '0;
    i_arprot  = '0;
    i_arvalid = 1'b0;
    i_wid     = '0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wlast   = 1'b0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b1;
    i_rready  = 1'b1;
    repeat (4) @(posedge i_aclk);
    @(negedge i_aclk);
    i_arst_n = 1'b1;

    // Fill the whole array so every read has a known value
    for (int k = 0; k < 16; k++) write_burst(4'h0, k * 128, 15, 3, BURST_INCR, 1'b1);

    write_burst(4'h3, 32'd128, 0, 3, BURST_INCR, 1'b0);
    read_burst(4'h5, 32'd128, 0, 3, BURST_INCR);
    repeat (12) random_incr();
    wrap_set();
    write_read(32'd512, 3, 3, BURST_FIXED);

    bp_on = 1'b1;
    repeat (6) random_incr();
    wrap_set();
    bp_on = 1'b0;

    write_read(MEM_BYTES - 24, 7, 3, BURST_INCR);
    write_read(32'd4096, 3, 3, BURST_INCR);
    write_read(MEM_BYTES - 32, 7, 3, BURST_INCR);

    // Low words alias the out-of-range beats above
    read_burst(4'h9, 32'd0, 15, 3, BURST_INCR);

    repeat (4) @(posedge i_aclk);
    $display("Error counts: R %0d, B %0d, other %0d", r_errs, b_errs, other_errs);
    if (r_errs == 0 && b_errs == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
